// File: project.f
design/spi_xip_pkg.sv
design/spi_clock_gen.sv
design/spi_shift_reg.sv
design/spi_master_regs.sv
design/apb_xip_bridge.sv
design/spi_xip_apb_top.sv
tests/spi_flash_model.sv
tests/tb_spi_xip.sv

// File: tests/spi_xip_trace.txt
# kind addr wdata exp_prdata exp_pslverr exp_irq (irq sampled after the access)
# W write, R read, P poll CTRL until busy clears, E write that must end in pslverr
W 10001014 0000beef 00000000 0 0
R 10001014 00000000 0000beef 0 0
W 10001018 0000005a 00000000 0 0
R 10001018 00000000 0000005a 0 0
W 10001004 cafef00d 00000000 0 0
R 10001004 00000000 cafef00d 0 0
W 10001018 00000000 00000000 0 0
R 30000010 00000000 b5b4b7b6 0 0
R 30000123 00000000 87808182 0 0
R 30fedcb9 00000000 c0c3c2c5 0 0
R 300001fe 00000000 5a5ba7a6 0 0
R 10001014 00000000 00000001 0 0
E 30000040 deadbeef 00000000 1 0
R 20000000 00000000 00000000 1 0
R 10001020 00000000 00000000 1 0
W 10001000 000000c3 00000000 0 0
W 10001010 00001108 00000000 0 0
P 10001010 00000000 00001008 0 1
W 10001010 00001008 00000000 0 0

// File: tests/tb_spi_xip.sv
module tb_spi_xip
  import spi_xip_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // Windows and divider the DUT is built with
  localparam addr_t flash_base  = 32'h3000_0000;
  localparam addr_t flash_limit = 32'h3fff_ffff;
  localparam addr_t ss_addr     = 32'h1000_1018;
  localparam int    xip_divider = 1;

  logic        clock;
  logic        reset;
  addr_t       paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  data_t       pwdata;
  logic [3:0]  pstrb;
  logic [2:0]  pprot;
  logic        pready;
  data_t       prdata;
  logic        pslverr;
  logic        sck;
  logic [7:0]  ss_n;
  logic        mosi;
  logic        miso;
  logic        irq;
  logic [7:0]  flash_opcode;
  logic [23:0] flash_addr;

  logic [31:0] lfsr_q      = 32'h85c4;
  int          cycles      = 0;
  // Provisional limit until the trace length is known
  int          cycle_limit = 100000;

  // One entry per trace line
  logic [7:0]  kind_q[$];
  addr_t       addr_q[$];
  data_t       wdata_q[$];
  data_t       exp_rd_q[$];
  logic        exp_err_q[$];
  logic        exp_irq_q[$];

  spi_xip_apb_top i_spi_xip_apb_top (
    .clock     (clock),
    .reset     (reset),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .pstrb_i   (pstrb),
    .pprot_i   (pprot),
    .pready_o  (pready),
    .prdata_o  (prdata),
    .pslverr_o (pslverr),
    .sck_o     (sck),
    .ss_n_o    (ss_n),
    .mosi_o    (mosi),
    .miso_i    (miso),
    .irq_o     (irq)
  );

  // Flash sits on select 0
  spi_flash_model i_spi_flash_model (
    .sck_i    (sck),
    .ss_n_i   (ss_n[0]),
    .mosi_i   (mosi),
    .miso_o   (miso),
    .opcode_o (flash_opcode),
    .addr_o   (flash_addr)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Galois LFSR stepped once per bit
  function automatic logic next_random_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      stop_with_failure($sformatf("timeout after %0d cycles, trace not finished", cycles));
    end
  end

  // One APB access that starts and ends 1 ns after a rising edge
  task automatic apb_transfer(input logic write, input addr_t addr, input data_t wdata,
                              output data_t rdata, output logic err, output logic ss0);
    logic [1:0] gap;
    gap[0] = next_random_bit();
    gap[1] = next_random_bit();
    repeat (gap) begin
      @(posedge clock);
      #1;
    end
    // Setup phase
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clock);
    #1;
    penable = 1'b1;
    // Outputs are settled mid cycle
    do begin
      @(negedge clock);
    end while (!pready);
    rdata = prdata;
    err   = pslverr;
    ss0   = ss_n[0];
    @(posedge clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  initial begin
    int         fd;
    int         n;
    string      line;
    logic [7:0] kind;
    addr_t      addr;
    data_t      wdata;
    data_t      exp_rd;
    logic       exp_err;
    logic       exp_irq;
    data_t      rd;
    logic       err;
    logic       ss0;
    logic [7:0] ss_before;

    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = 4'hf;
    pprot   = 3'b000;

    fd = $fopen("tests/spi_xip_trace.txt", "r");
    assert (fd != 0) else stop_with_failure("could not open tests/spi_xip_trace.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%c %h %h %h %h %h", kind, addr, wdata, exp_rd, exp_err, exp_irq);
        if (n == 6) begin
          kind_q.push_back(kind);
          addr_q.push_back(addr);
          wdata_q.push_back(wdata);
          exp_rd_q.push_back(exp_rd);
          exp_err_q.push_back(exp_err);
          exp_irq_q.push_back(exp_irq);
        end
      end
    end
    $fclose(fd);
    assert (kind_q.size() > 0) else stop_with_failure("trace file holds no transactions");
    // Room for a full 128 bit frame plus overhead per line
    cycle_limit = kind_q.size() * (128 * (xip_divider + 1) + 40) * 2;

    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;

    // Idle outputs after reset
    @(negedge clock);
    assert (pready == 1'b0) else stop_with_failure(
      $sformatf("[FAIL] pready_o: got 0x%0h, expected 0x0", pready));
    assert (pslverr == 1'b0) else stop_with_failure(
      $sformatf("[FAIL] pslverr_o: got 0x%0h, expected 0x0", pslverr));
    assert (irq == 1'b0) else stop_with_failure(
      $sformatf("[FAIL] irq_o: got 0x%0h, expected 0x0", irq));
    assert (sck == 1'b0) else stop_with_failure(
      $sformatf("[FAIL] sck_o: got 0x%0h, expected 0x0", sck));
    assert (mosi == 1'b0) else stop_with_failure(
      $sformatf("[FAIL] mosi_o: got 0x%0h, expected 0x0", mosi));
    assert (ss_n == 8'hff) else stop_with_failure(
      $sformatf("[FAIL] ss_n_o: got 0x%02h, expected 0xff", ss_n));
    @(posedge clock);
    #1;

    for (int i = 0; i < kind_q.size(); i++) begin
      kind      = kind_q[i];
      addr      = addr_q[i];
      ss_before = ss_n;
      case (kind)
        "W", "E": apb_transfer(1'b1, addr, wdata_q[i], rd, err, ss0);
        "R":      apb_transfer(1'b0, addr, '0, rd, err, ss0);
        "P": begin
          // Read CTRL until go/busy drops
          do begin
            apb_transfer(1'b0, addr, '0, rd, err, ss0);
          end while (rd[8] && !err);
        end
        default: stop_with_failure($sformatf("unknown kind on trace line %0d", i));
      endcase

      assert (err == exp_err_q[i]) else stop_with_failure(
        $sformatf("[FAIL] pslverr_o: got 0x%0h, expected 0x%0h", err, exp_err_q[i]));
      if (err) begin
        // Error must leave the selects alone
        assert (ss_n == ss_before) else stop_with_failure(
          $sformatf("[FAIL] ss_n_o: got 0x%02h, expected 0x%02h", ss_n, ss_before));
      end else if (kind == "R" || kind == "P") begin
        assert (rd == exp_rd_q[i]) else stop_with_failure(
          $sformatf("[FAIL] prdata_o: got 0x%08h, expected 0x%08h", rd, exp_rd_q[i]));
      end
      if (kind == "W" && addr == ss_addr) begin
        assert (ss_n == ~wdata_q[i][7:0]) else stop_with_failure(
          $sformatf("[FAIL] ss_n_o: got 0x%02h, expected 0x%02h", ss_n, ~wdata_q[i][7:0]));
      end
      // XIP read needs the right flash command and a released select
      if (kind == "R" && !err && addr >= flash_base && addr <= flash_limit) begin
        assert (flash_opcode == 8'h03) else stop_with_failure(
          $sformatf("[FAIL] flash opcode: got 0x%02h, expected 0x03", flash_opcode));
        assert (flash_addr == 24'(addr - flash_base)) else stop_with_failure(
          $sformatf("[FAIL] flash address: got 0x%06h, expected 0x%06h",
                    flash_addr, 24'(addr - flash_base)));
        assert (ss0 == 1'b1) else stop_with_failure(
          $sformatf("[FAIL] ss_n_o[0] at pready: got 0x%0h, expected 0x1", ss0));
      end
      assert (irq == exp_irq_q[i]) else stop_with_failure(
        $sformatf("[FAIL] irq_o: got 0x%0h, expected 0x%0h", irq, exp_irq_q[i]));
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// File: tests/spi_flash_model.sv
module spi_flash_model (
  input  logic        sck_i,
  input  logic        ss_n_i,
  input  logic        mosi_i,
  output logic        miso_o,
  output logic [7:0]  opcode_o,
  output logic [23:0] addr_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Command shift register and count of command bits seen
  logic [31:0] cmd_sr;
  int          cmd_bits;
  // Read pointer for the data phase
  logic [23:0] byte_addr;
  logic [2:0]  bit_idx;
  logic [7:0]  cur_byte;

  // Array contents, a pure function of the address
  function automatic logic [7:0] byte_at(input logic [23:0] addr);
    return addr[7:0] ^ addr[15:8] ^ 8'ha5;
  endfunction

  initial begin
    miso_o    = 1'b0;
    opcode_o  = '0;
    addr_o    = '0;
    cmd_sr    = '0;
    cmd_bits  = 0;
    byte_addr = '0;
    bit_idx   = 3'd7;
    cur_byte  = '0;
  end

  // Deselect ends the frame
  always @(posedge ss_n_i) begin
    cmd_bits = 0;
    miso_o   = 1'b0;
  end

  // Opcode and address arrive on rising sck
  always @(posedge sck_i) begin
    if (!ss_n_i && cmd_bits < 32) begin
      cmd_sr   = {cmd_sr[30:0], mosi_i};
      cmd_bits = cmd_bits + 1;
      if (cmd_bits == 32) begin
        // Report what was decoded
        opcode_o  = cmd_sr[31:24];
        addr_o    = cmd_sr[23:0];
        byte_addr = cmd_sr[23:0];
        bit_idx   = 3'd7;
      end
    end
  end

  // Data bits leave on falling sck, MSB first
  always @(negedge sck_i) begin
    if (!ss_n_i && cmd_bits == 32) begin
      cur_byte = byte_at(byte_addr);
      miso_o   = cur_byte[bit_idx];
      if (bit_idx == 3'd0) begin
        byte_addr = byte_addr + 24'd1;
      end
      // Wraps back to 7 for the next byte
      bit_idx = bit_idx - 3'd1;
    end
  end

endmodule

// File: design/spi_xip_apb_top.sv
module spi_xip_apb_top
  import spi_xip_pkg::*;
#(
  parameter addr_t  flash_base  = 32'h3000_0000,
  parameter addr_t  flash_limit = 32'h3fff_ffff,
  parameter addr_t  regs_base   = 32'h1000_1000,
  parameter addr_t  regs_limit  = 32'h1000_101f,
  parameter integer ss_width    = 8,
  parameter div_t   xip_divider = 16'h0001
) (
  input  logic                clock,
  input  logic                reset,
  // APB slave
  input  addr_t               paddr_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  data_t               pwdata_i,
  input  logic [3:0]          pstrb_i,
  input  logic [2:0]          pprot_i,
  output logic                pready_o,
  output data_t               prdata_o,
  output logic                pslverr_o,
  // SPI pins
  output logic                sck_o,
  output logic [ss_width-1:0] ss_n_o,
  output logic                mosi_o,
  input  logic                miso_i,
  output logic                irq_o
);

  // Register bus between bridge and register block
  logic      reg_valid;
  logic      reg_ready;
  reg_addr_t reg_addr;
  logic      reg_write;
  data_t     reg_wdata;
  data_t     reg_rdata;

  // Transfer control
  logic         start;
  char_len_t    char_len;
  div_t         divider;
  logic         busy;
  logic         done_stb;
  logic         sample_stb;
  logic         shift_stb;
  logic [127:0] tx_data;
  logic [127:0] rx_data;

  apb_xip_bridge #(
    .flash_base  (flash_base),
    .flash_limit (flash_limit),
    .regs_base   (regs_base),
    .regs_limit  (regs_limit),
    .xip_divider (xip_divider)
  ) i_apb_xip_bridge (
    .clock       (clock),
    .reset       (reset),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .pready_o    (pready_o),
    .prdata_o    (prdata_o),
    .pslverr_o   (pslverr_o),
    .reg_valid_o (reg_valid),
    .reg_addr_o  (reg_addr),
    .reg_write_o (reg_write),
    .reg_wdata_o (reg_wdata),
    .reg_ready_i (reg_ready),
    .reg_rdata_i (reg_rdata)
  );

  spi_master_regs #(
    .ss_width (ss_width)
  ) i_spi_master_regs (
    .clock       (clock),
    .reset       (reset),
    .reg_valid_i (reg_valid),
    .reg_addr_i  (reg_addr),
    .reg_write_i (reg_write),
    .reg_wdata_i (reg_wdata),
    .reg_ready_o (reg_ready),
    .reg_rdata_o (reg_rdata),
    .busy_i      (busy),
    .done_stb_i  (done_stb),
    .rx_data_i   (rx_data),
    .start_o     (start),
    .char_len_o  (char_len),
    .divider_o   (divider),
    .tx_data_o   (tx_data),
    .ss_n_o      (ss_n_o),
    .irq_o       (irq_o)
  );

  spi_clock_gen i_spi_clock_gen (
    .clock        (clock),
    .reset        (reset),
    .start_i      (start),
    .char_len_i   (char_len),
    .divider_i    (divider),
    .sck_o        (sck_o),
    .sample_stb_o (sample_stb),
    .shift_stb_o  (shift_stb),
    .busy_o       (busy),
    .done_stb_o   (done_stb)
  );

  spi_shift_reg i_spi_shift_reg (
    .clock        (clock),
    .reset        (reset),
    .start_i      (start),
    .char_len_i   (char_len),
    .tx_data_i    (tx_data),
    .sample_stb_i (sample_stb),
    .shift_stb_i  (shift_stb),
    .miso_i       (miso_i),
    .mosi_o       (mosi_o),
    .rx_data_o    (rx_data)
  );

endmodule

// File: design/apb_xip_bridge.sv
module apb_xip_bridge
  import spi_xip_pkg::*;
#(
  parameter addr_t flash_base  = 32'h3000_0000,
  parameter addr_t flash_limit = 32'h3fff_ffff,
  parameter addr_t regs_base   = 32'h1000_1000,
  parameter addr_t regs_limit  = 32'h1000_101f,
  parameter div_t  xip_divider = 16'h0001
) (
  input  logic      clock,
  input  logic      reset,
  input  addr_t     paddr_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  data_t     pwdata_i,
  output logic      pready_o,
  output data_t     prdata_o,
  output logic      pslverr_o,
  output logic      reg_valid_o,
  output reg_addr_t reg_addr_o,
  output logic      reg_write_o,
  output data_t     reg_wdata_o,
  input  logic      reg_ready_i,
  input  data_t     reg_rdata_i
);

  bridge_state_e state_q;
  bridge_state_e state_d;
  data_t         prdata_q;
  addr_t         flash_offset;
  addr_t         regs_offset;
  logic          flash_hit;
  logic          regs_hit;
  logic          bad_access;

  // Window decode, paddr is held by the master for the whole access
  assign flash_hit    = (paddr_i >= flash_base) && (paddr_i <= flash_limit);
  assign regs_hit     = (paddr_i >= regs_base) && (paddr_i <= regs_limit);
  // Flash window is read only
  assign bad_access   = !regs_hit && !(flash_hit && !pwrite_i);
  assign flash_offset = paddr_i - flash_base;
  assign regs_offset  = paddr_i - regs_base;

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        // Errors are caught in setup so the response lands in the first access cycle
        if (psel_i && !penable_i && bad_access) begin
          state_d = error_resp;
        end else if (psel_i && penable_i) begin
          if (regs_hit) begin
            state_d = pass_access;
          end else if (flash_hit && !pwrite_i) begin
            state_d = send_cmd;
          end else begin
            state_d = error_resp;
          end
        end
      end
      pass_access:   if (reg_ready_i) state_d = idle;
      send_cmd:      if (reg_ready_i) state_d = set_divider;
      set_divider:   if (reg_ready_i) state_d = set_ss;
      set_ss:        if (reg_ready_i) state_d = go_busy;
      go_busy:       if (reg_ready_i) state_d = wait_complete;
      // Keep polling CTRL until go/busy reads back low
      wait_complete: if (reg_ready_i && !reg_rdata_i[ctrl_go_bit]) state_d = clear_ss;
      clear_ss:      if (reg_ready_i) state_d = read_data;
      read_data:     if (reg_ready_i) state_d = done;
      // Single cycle of pready, the master leaves the access phase after it
      done:          state_d = idle;
      error_resp:    state_d = idle;
      default:       state_d = idle;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Word returned for the XIP read
  always_ff @(posedge clock) begin
    if (state_q == read_data && reg_ready_i) begin
      prdata_q <= reg_rdata_i;
    end
  end

  // Register bus request, held steady by the state until ready
  always_comb begin
    reg_valid_o = 1'b1;
    reg_write_o = 1'b1;
    reg_addr_o  = reg_rx0_tx0;
    reg_wdata_o = '0;
    case (state_q)
      pass_access: begin
        reg_addr_o  = regs_offset[4:0];
        reg_write_o = pwrite_i;
        reg_wdata_o = pwdata_i;
      end
      send_cmd: begin
        // Command in TX1 so it leads the 64 bit frame
        reg_addr_o  = reg_rx1_tx1;
        reg_wdata_o = {xip_opcode, flash_offset[23:0]};
      end
      set_divider: begin
        reg_addr_o  = reg_divider;
        reg_wdata_o = data_t'(xip_divider);
      end
      set_ss: begin
        reg_addr_o  = reg_ss;
        reg_wdata_o = 32'h0000_0001;
      end
      go_busy: begin
        reg_addr_o  = reg_ctrl;
        reg_wdata_o = data_t'(xip_char_len) | (data_t'(1) << ctrl_go_bit);
      end
      wait_complete: begin
        reg_addr_o  = reg_ctrl;
        reg_write_o = 1'b0;
      end
      clear_ss: begin
        reg_addr_o  = reg_ss;
      end
      read_data: begin
        // Last 32 bits shifted in
        reg_addr_o  = reg_rx0_tx0;
        reg_write_o = 1'b0;
      end
      default: begin
        reg_valid_o = 1'b0;
        reg_write_o = 1'b0;
      end
    endcase
  end

  // APB response
  assign pready_o  = ((state_q == pass_access) && reg_ready_i) ||
                     (state_q == done) || (state_q == error_resp);
  assign pslverr_o = (state_q == error_resp);
  assign prdata_o  = (state_q == pass_access) ? reg_rdata_i :
                     (state_q == done) ? prdata_q : '0;

endmodule

// File: design/spi_master_regs.sv
module spi_master_regs
  import spi_xip_pkg::*;
#(
  parameter integer ss_width = 8
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                reg_valid_i,
  input  reg_addr_t           reg_addr_i,
  input  logic                reg_write_i,
  input  data_t               reg_wdata_i,
  output logic                reg_ready_o,
  output data_t               reg_rdata_o,
  input  logic                busy_i,
  input  logic                done_stb_i,
  input  logic [127:0]        rx_data_i,
  output logic                start_o,
  output char_len_t           char_len_o,
  output div_t                divider_o,
  output logic [127:0]        tx_data_o,
  output logic [ss_width-1:0] ss_n_o,
  output logic                irq_o
);

  logic                ready_q;
  logic                start_q;
  logic                irq_q;
  logic                ie_q;
  char_len_t           char_len_q;
  div_t                divider_q;
  logic [ss_width-1:0] ss_q;
  // TX and RX share storage and the RX image overwrites it at transfer end
  logic [127:0]        data_q;
  logic                wr_stb;
  logic                xfer_active;
  logic                locked;
  data_t               ctrl_rd;

  assign wr_stb      = reg_valid_i && ready_q && reg_write_i;
  // Start pulse counts as busy so a write right after go is still blocked
  assign xfer_active = busy_i || start_q;
  // SS stays writable during a transfer
  assign locked      = xfer_active && (reg_addr_i != reg_ss);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ready_q    <= 1'b0;
      start_q    <= 1'b0;
      irq_q      <= 1'b0;
      ie_q       <= 1'b0;
      char_len_q <= '0;
      divider_q  <= '0;
      ss_q       <= '0;
    end else begin
      // One cycle of latency per request
      ready_q <= reg_valid_i && !ready_q;
      start_q <= 1'b0;
      if (done_stb_i && ie_q) begin
        irq_q <= 1'b1;
      end
      if (wr_stb && !locked) begin
        case (reg_addr_i)
          reg_ctrl: begin
            char_len_q <= reg_wdata_i[6:0];
            ie_q       <= reg_wdata_i[ctrl_ie_bit];
            start_q    <= reg_wdata_i[ctrl_go_bit];
            irq_q      <= 1'b0;
          end
          reg_divider: divider_q <= reg_wdata_i[15:0];
          reg_ss:      ss_q      <= reg_wdata_i[ss_width-1:0];
          default: ;
        endcase
      end
    end
  end

  // Data words at offsets 0x00 to 0x0c
  always_ff @(posedge clock) begin
    if (done_stb_i) begin
      data_q <= rx_data_i;
    end else if (wr_stb && !locked && !reg_addr_i[4]) begin
      data_q[reg_addr_i[3:2]*32 +: 32] <= reg_wdata_i;
    end
  end

  // Read mux with live busy in CTRL
  always_comb begin
    ctrl_rd              = '0;
    ctrl_rd[6:0]         = char_len_q;
    ctrl_rd[ctrl_go_bit] = xfer_active;
    ctrl_rd[ctrl_ie_bit] = ie_q;
    case (reg_addr_i)
      reg_rx0_tx0, reg_rx1_tx1, reg_rx2_tx2, reg_rx3_tx3: begin
        reg_rdata_o = data_q[reg_addr_i[3:2]*32 +: 32];
      end
      reg_ctrl:    reg_rdata_o = ctrl_rd;
      reg_divider: reg_rdata_o = data_t'(divider_q);
      reg_ss:      reg_rdata_o = data_t'(ss_q);
      default:     reg_rdata_o = '0;
    endcase
  end

  assign reg_ready_o = ready_q;
  assign start_o     = start_q;
  assign char_len_o  = char_len_q;
  assign divider_o   = divider_q;
  assign tx_data_o   = data_q;
  // Selects are active low on the pins
  assign ss_n_o      = ~ss_q;
  assign irq_o       = irq_q;

endmodule

// File: design/spi_shift_reg.sv
module spi_shift_reg
  import spi_xip_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         start_i,
  input  char_len_t    char_len_i,
  input  logic [127:0] tx_data_i,
  input  logic         sample_stb_i,
  input  logic         shift_stb_i,
  input  logic         miso_i,
  output logic         mosi_o,
  output logic [127:0] rx_data_o
);

  logic [127:0] tx_sr_q;
  logic [127:0] rx_sr_q;
  logic [127:0] tx_aligned;
  logic         mosi_q;
  bit_count_t   len;

  assign len = (char_len_i == '0) ? 8'd128 : bit_count_t'(char_len_i);

  // Move bit len-1 up to bit 127 so MSB first leaves from the top
  assign tx_aligned = tx_data_i << (8'd128 - len);

  // Pin level only
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mosi_q <= 1'b0;
    end else if (start_i) begin
      mosi_q <= tx_aligned[127];
    end else if (shift_stb_i) begin
      mosi_q <= tx_sr_q[127];
    end
  end

  // Bits still to send, first one already on mosi
  always_ff @(posedge clock) begin
    if (start_i) begin
      tx_sr_q <= tx_aligned << 1;
    end else if (shift_stb_i) begin
      tx_sr_q <= tx_sr_q << 1;
    end
  end

  // Received bits enter at bit 0
  always_ff @(posedge clock) begin
    if (sample_stb_i) begin
      rx_sr_q <= {rx_sr_q[126:0], miso_i};
    end
  end

  assign mosi_o    = mosi_q;
  assign rx_data_o = rx_sr_q;

endmodule

// File: design/spi_clock_gen.sv
module spi_clock_gen
  import spi_xip_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      start_i,
  input  char_len_t char_len_i,
  input  div_t      divider_i,
  output logic      sck_o,
  output logic      sample_stb_o,
  output logic      shift_stb_o,
  output logic      busy_o,
  output logic      done_stb_o
);

  logic       busy_q;
  logic       sck_q;
  logic       tick;
  div_t       div_cnt_q;
  bit_count_t bit_cnt_q;

  // End of a half period
  assign tick = busy_q && (div_cnt_q == '0);

  // Rising sck edge samples, falling edge shifts
  assign sample_stb_o = tick && !sck_q;
  assign shift_stb_o  = tick && sck_q && (bit_cnt_q != '0);
  // Falling edge after the last sample closes the frame
  assign done_stb_o   = tick && sck_q && (bit_cnt_q == '0);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q    <= 1'b0;
      sck_q     <= 1'b0;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (start_i) begin
      busy_q    <= 1'b1;
      sck_q     <= 1'b0;
      div_cnt_q <= divider_i;
      // Length zero means a full 128 bit character
      bit_cnt_q <= (char_len_i == '0) ? 8'd128 : bit_count_t'(char_len_i);
    end else if (busy_q) begin
      if (tick) begin
        div_cnt_q <= divider_i;
        if (done_stb_o) begin
          busy_q <= 1'b0;
          sck_q  <= 1'b0;
        end else begin
          sck_q <= !sck_q;
        end
        if (sample_stb_o) begin
          bit_cnt_q <= bit_cnt_q - 8'd1;
        end
      end else begin
        div_cnt_q <= div_cnt_q - 16'd1;
      end
    end
  end

  assign sck_o  = sck_q;
  assign busy_o = busy_q;

endmodule

// File: design/spi_xip_pkg.sv
package spi_xip_pkg;

  // Bus and register widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [4:0]  reg_addr_t;
  // Zero encodes a 128 bit character
  typedef logic [6:0]  char_len_t;
  typedef logic [7:0]  bit_count_t;
  typedef logic [15:0] div_t;

  // SPI master register map
  localparam reg_addr_t reg_rx0_tx0 = 5'h00;
  localparam reg_addr_t reg_rx1_tx1 = 5'h04;
  localparam reg_addr_t reg_rx2_tx2 = 5'h08;
  localparam reg_addr_t reg_rx3_tx3 = 5'h0c;
  localparam reg_addr_t reg_ctrl    = 5'h10;
  localparam reg_addr_t reg_divider = 5'h14;
  localparam reg_addr_t reg_ss      = 5'h18;

  // CTRL fields, char length sits in bits 6:0
  localparam int ctrl_go_bit = 8;
  localparam int ctrl_ie_bit = 12;

  // Flash read command and XIP frame length
  localparam logic [7:0] xip_opcode   = 8'h03;
  localparam char_len_t  xip_char_len = 7'h40;

  typedef enum logic [3:0] {
    idle,
    pass_access,
    send_cmd,
    set_divider,
    set_ss,
    go_busy,
    wait_complete,
    clear_ss,
    read_data,
    done,
    error_resp
  } bridge_state_e;

endpackage
